// File: r24_ctrl.f
+incdir+tests
source/r24_ctrl_pkg.sv
source/ctrl_regs.sv
source/usb_route.sv
source/led_ddac.sv
source/r24_ctrl_top.sv
tests/r24_ctrl_tb.sv

// File: source/ctrl_regs.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// APB register block for the control window
////////////////////////////////////////////////////////////////////////////

module ctrl_regs
    import r24_ctrl_pkg::*;
#(
    parameter logic [APB_ADDR_W-WINDOW_LSB-1:0] BLOCK_BASE = 20'h43C04,
    parameter int LED_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 reset,

    // APB slave
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  apb_addr_t            paddr,
    input  apb_data_t            pwdata,
    output apb_data_t            prdata,

    // FIFO status and read word
    input  logic                 usb_wr_full,
    input  logic                 usb_rd_empty,
    input  usb_data_t            usb_rd_data,

    // Towards the router
    output route_mode_e          route_mode,
    output usb_data_t            reg_wr_data,
    output usb_be_t              reg_wr_be,
    output logic                 reg_push,
    output logic                 reg_pop,

    // Dimmer levels
    output logic [LED_DEPTH-1:0] led0_brightness,
    output logic [LED_DEPTH-1:0] led1_brightness
);

    logic        sel;       // Our window addressed
    logic        wr_stb;    // Write access cycle
    reg_offset_e offset;
    logic        overflow;  // Sticky flag for a push dropped on a full FIFO

    assign sel    = psel && (paddr[APB_ADDR_W-1:WINDOW_LSB] == BLOCK_BASE);
    assign wr_stb = sel && penable && pwrite;
    assign offset = reg_offset_e'(paddr[WINDOW_LSB-1:0]);

    ////////////////////////////////////////////////////////////////////////
    // Read mux with zero latency
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        prdata = '0; // Outside window or unmapped
        if (sel) begin
            case (offset)
                REG_CTRL:        prdata = apb_data_t'(route_mode);
                REG_STATUS:      prdata = {29'd0, overflow, usb_rd_empty, usb_wr_full};
                REG_LED0:        prdata = apb_data_t'(led0_brightness);
                REG_LED1:        prdata = apb_data_t'(led1_brightness);
                REG_USB_WR_DATA: prdata = apb_data_t'(reg_wr_data);
                REG_USB_WR_BE:   prdata = apb_data_t'(reg_wr_be);
                REG_USB_RD_DATA: prdata = apb_data_t'(usb_rd_data);
                default:         prdata = '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Control registers and strobes
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            route_mode      <= ROUTE_IDLE;
            reg_wr_be       <= '1;
            led0_brightness <= '0;
            led1_brightness <= '0;
            overflow        <= 1'b0;
            reg_push        <= 1'b0;
            reg_pop         <= 1'b0;
        end else begin
            // Strobes are single cycle
            reg_push <= 1'b0;
            reg_pop  <= 1'b0;

            if (wr_stb) begin
                case (offset)
                    REG_CTRL:      route_mode <= route_mode_e'(pwdata[1:0]);
                    REG_STATUS:    overflow <= 1'b0; // Any write clears
                    REG_LED0:      led0_brightness <= pwdata[LED_DEPTH-1:0];
                    REG_LED1:      led1_brightness <= pwdata[LED_DEPTH-1:0];
                    REG_USB_WR_BE: reg_wr_be <= pwdata[USB_BE_W-1:0];
                    REG_USB_WR_DATA: begin
                        if (usb_wr_full)
                            overflow <= 1'b1; // Word is lost
                        else
                            reg_push <= 1'b1;
                    end
                    REG_USB_RD_DATA: reg_pop <= 1'b1; // Data ignored
                    default: ;
                endcase
            end
        end
    end

    // Pushed word held until the next data write
    always_ff @(posedge clk) begin
        if (wr_stb && offset == REG_USB_WR_DATA && !usb_wr_full)
            reg_wr_data <= pwdata;
    end

    ////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////

    // Back to back pushes need two writes so they never touch
    push_single_cycle_a : assert property (
        @(posedge clk) disable iff (reset)
        reg_push |=> !reg_push
    );

    // The write that raises overflow never also pushes
    full_write_no_push_a : assert property (
        @(posedge clk) disable iff (reset)
        reg_push |-> !$rose(overflow)
    );

endmodule

`default_nettype wire

// File: source/led_ddac.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// First-order delta-sigma LED dimmer
////////////////////////////////////////////////////////////////////////////

module led_ddac #(
    parameter int LED_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [LED_DEPTH-1:0] brightness,
    output logic                 led
);

    logic [LED_DEPTH-1:0] acc;
    logic [LED_DEPTH:0]   sum; // Extra bit holds the carry

    assign sum = {1'b0, acc} + {1'b0, brightness};

    // Carry density tracks brightness / 2**LED_DEPTH
    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
            led <= 1'b0;
        end else begin
            acc <= sum[LED_DEPTH-1:0]; // Wraps, remainder kept
            led <= sum[LED_DEPTH];     // Pin one cycle behind the sum
        end
    end

endmodule

`default_nettype wire

// File: source/r24_ctrl_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Shared widths, types and encodings for the control plane
////////////////////////////////////////////////////////////////////////////

package r24_ctrl_pkg;

    // APB bus
    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;

    // USB FIFO side
    localparam int USB_DATA_W = 32;
    localparam int USB_BE_W   = 4;

    typedef logic [USB_DATA_W-1:0] usb_data_t;
    typedef logic [USB_BE_W-1:0]   usb_be_t;

    // Channel A ADC byte
    localparam int ADC_W = 8;
    typedef logic [ADC_W-1:0] adc_sample_t;

    localparam int WINDOW_LSB = 12; // 4 KB register window

    // Source feeding the USB write FIFO
    typedef enum logic [1:0] {
        ROUTE_REGS = 2'd0,  // Register pushes and pops
        ROUTE_IDLE = 2'd1,
        ROUTE_ADC  = 2'd2,  // Free-running ADC stream
        ROUTE_LOOP = 2'd3   // USB read data back out
    } route_mode_e;

    // Offsets inside the window
    typedef enum logic [WINDOW_LSB-1:0] {
        REG_CTRL        = 12'h000,
        REG_STATUS      = 12'h004,
        REG_LED0        = 12'h008,
        REG_LED1        = 12'h00C,
        REG_USB_WR_DATA = 12'h010,
        REG_USB_WR_BE   = 12'h014,
        REG_USB_RD_DATA = 12'h018
    } reg_offset_e;

endpackage

`default_nettype wire

// File: source/r24_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Control plane top level
////////////////////////////////////////////////////////////////////////////

module r24_ctrl_top
    import r24_ctrl_pkg::*;
#(
    parameter logic [APB_ADDR_W-WINDOW_LSB-1:0] BLOCK_BASE = 20'h43C04,
    parameter int LED_DEPTH = 16
) (
    input  logic        clk,
    input  logic        reset,

    // APB slave
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  apb_data_t   pwdata,
    output apb_data_t   prdata,

    input  adc_sample_t adc_a_data,

    // USB FIFOs, external
    input  usb_data_t   usb_rd_data,
    input  usb_be_t     usb_rd_be,
    input  logic        usb_rd_valid,
    input  logic        usb_rd_empty,
    input  logic        usb_wr_full,
    output usb_data_t   usb_wr_data,
    output usb_be_t     usb_wr_be,
    output logic        usb_wr_en,
    output logic        usb_rd_en,

    output logic        led0,
    output logic        led1
);

    route_mode_e          route_mode;
    usb_data_t            reg_wr_data;
    usb_be_t              reg_wr_be;
    logic                 reg_push;
    logic                 reg_pop;
    logic [LED_DEPTH-1:0] led0_brightness;
    logic [LED_DEPTH-1:0] led1_brightness;

    ctrl_regs #(
        .BLOCK_BASE (BLOCK_BASE),
        .LED_DEPTH  (LED_DEPTH)
    ) regs_i (
        .clk             (clk),
        .reset           (reset),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .usb_wr_full     (usb_wr_full),
        .usb_rd_empty    (usb_rd_empty),
        .usb_rd_data     (usb_rd_data),
        .route_mode      (route_mode),
        .reg_wr_data     (reg_wr_data),
        .reg_wr_be       (reg_wr_be),
        .reg_push        (reg_push),
        .reg_pop         (reg_pop),
        .led0_brightness (led0_brightness),
        .led1_brightness (led1_brightness)
    );

    // Combinational mux into the write FIFO
    usb_route route_i (
        .clk          (clk),
        .reset        (reset),
        .route_mode   (route_mode),
        .reg_wr_data  (reg_wr_data),
        .reg_wr_be    (reg_wr_be),
        .reg_push     (reg_push),
        .reg_pop      (reg_pop),
        .adc_a_data   (adc_a_data),
        .usb_rd_data  (usb_rd_data),
        .usb_rd_be    (usb_rd_be),
        .usb_rd_valid (usb_rd_valid),
        .usb_wr_full  (usb_wr_full),
        .usb_wr_data  (usb_wr_data),
        .usb_wr_be    (usb_wr_be),
        .usb_wr_en    (usb_wr_en),
        .usb_rd_en    (usb_rd_en)
    );

    ////////////////////////////////////////////////////////////////////////
    // LED dimmers
    ////////////////////////////////////////////////////////////////////////

    led_ddac #(.LED_DEPTH(LED_DEPTH)) led0_i (
        .clk        (clk),
        .reset      (reset),
        .brightness (led0_brightness),
        .led        (led0)
    );

    led_ddac #(.LED_DEPTH(LED_DEPTH)) led1_i (
        .clk        (clk),
        .reset      (reset),
        .brightness (led1_brightness),
        .led        (led1)
    );

endmodule

`default_nettype wire

// File: source/usb_route.sv
`timescale 1ns/1ns
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// USB write source selection
////////////////////////////////////////////////////////////////////////////

module usb_route
    import r24_ctrl_pkg::*;
(
    input  logic        clk,          // Assertion sampling only
    input  logic        reset,

    input  route_mode_e route_mode,

    // Register-driven traffic
    input  usb_data_t   reg_wr_data,
    input  usb_be_t     reg_wr_be,
    input  logic        reg_push,
    input  logic        reg_pop,

    input  adc_sample_t adc_a_data,

    // Read FIFO side
    input  usb_data_t   usb_rd_data,
    input  usb_be_t     usb_rd_be,
    input  logic        usb_rd_valid,
    input  logic        usb_wr_full,

    // Write FIFO side
    output usb_data_t   usb_wr_data,
    output usb_be_t     usb_wr_be,
    output logic        usb_wr_en,
    output logic        usb_rd_en
);

    always_comb begin
        // Idle values
        usb_wr_data = '0;
        usb_wr_be   = '1;
        usb_wr_en   = 1'b0;
        usb_rd_en   = 1'b0;
        case (route_mode)
            ROUTE_REGS: begin
                usb_wr_data = reg_wr_data;
                usb_wr_be   = reg_wr_be;
                usb_wr_en   = reg_push;
                usb_rd_en   = reg_pop;
            end
            ROUTE_ADC: begin
                usb_wr_data = usb_data_t'(adc_a_data); // Zero-extended byte
                usb_wr_en   = 1'b1;                    // Unconditional, full ignored
                usb_rd_en   = 1'b1;
            end
            ROUTE_LOOP: begin
                usb_wr_data = usb_rd_data;
                usb_wr_be   = usb_rd_be;
                usb_wr_en   = usb_rd_valid;
                usb_rd_en   = !usb_wr_full; // Stall reads while output is full
            end
            default: ; // ROUTE_IDLE
        endcase
    end

    // Loopback must not draw reads it cannot forward
    loop_backpressure_a : assert property (
        @(posedge clk) disable iff (reset)
        (route_mode == ROUTE_LOOP) |-> !(usb_rd_en && usb_wr_full)
    );

endmodule

`default_nettype wire

// File: tests/r24_ctrl_model.svh
`ifndef R24_CTRL_MODEL_SVH
`define R24_CTRL_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model, stepped once per rising edge
////////////////////////////////////////////////////////////////////////////

route_mode_e          m_mode;
usb_be_t              m_be;
usb_data_t            m_wr_data;          // Last word pushed
logic [LED_DEPTH-1:0] m_bright0, m_bright1;
logic [LED_DEPTH-1:0] m_acc0, m_acc1;     // Dimmer accumulators
logic                 m_pin0, m_pin1;     // Expected LED pins
logic                 m_ovf, m_push, m_pop;

// Inputs are the ones present in the cycle that this edge ends
task automatic model_step(input logic rst, sel, en, wr, input apb_addr_t addr,
                          input apb_data_t data, input logic wr_full);
    logic [LED_DEPTH:0] sum0;
    logic [LED_DEPTH:0] sum1;
    sum0 = m_acc0 + m_bright0;            // Widened, top bit is the carry
    sum1 = m_acc1 + m_bright1;
    if (rst) begin
        m_mode    = ROUTE_IDLE;
        m_be      = 4'hF;
        m_bright0 = '0;
        m_bright1 = '0;
        m_acc0    = '0;
        m_acc1    = '0;
        m_pin0    = 1'b0;
        m_pin1    = 1'b0;
        m_ovf     = 1'b0;
        m_push    = 1'b0;
        m_pop     = 1'b0;
    end else begin
        {m_pin0, m_acc0} = sum0;          // Old brightness feeds this edge
        {m_pin1, m_acc1} = sum1;
        m_push = 1'b0;
        m_pop  = 1'b0;
        if (sel && en && wr && addr[APB_ADDR_W-1:WINDOW_LSB] == BLOCK_BASE) begin
            case (addr[WINDOW_LSB-1:0])
                REG_CTRL:      m_mode = route_mode_e'(data[1:0]);
                REG_STATUS:    m_ovf = 1'b0;
                REG_LED0:      m_bright0 = data[LED_DEPTH-1:0];
                REG_LED1:      m_bright1 = data[LED_DEPTH-1:0];
                REG_USB_WR_BE: m_be = data[USB_BE_W-1:0];
                REG_USB_WR_DATA: begin
                    if (wr_full) begin
                        m_ovf = 1'b1;     // Dropped word
                    end else begin
                        m_push    = 1'b1;
                        m_wr_data = data;
                    end
                end
                REG_USB_RD_DATA: m_pop = 1'b1;
                default: ;
            endcase
        end
    end
endtask

// Read value of one address in the current cycle
function automatic apb_data_t predict_read(input apb_addr_t addr, input logic wr_full,
                                           input logic rd_empty, input usb_data_t rd_data);
    if (addr[APB_ADDR_W-1:WINDOW_LSB] != BLOCK_BASE)
        return '0;                        // Foreign window
    case (addr[WINDOW_LSB-1:0])
        REG_CTRL:        return apb_data_t'(m_mode);
        REG_STATUS:      return apb_data_t'({m_ovf, rd_empty, wr_full});
        REG_LED0:        return apb_data_t'(m_bright0);
        REG_LED1:        return apb_data_t'(m_bright1);
        REG_USB_WR_DATA: return m_wr_data;
        REG_USB_WR_BE:   return apb_data_t'(m_be);
        REG_USB_RD_DATA: return rd_data;
        default:         return '0;
    endcase
endfunction

// Router table for this cycle
task automatic predict_route(input adc_sample_t adc, input usb_data_t rd_data,
                             input usb_be_t rd_be, input logic rd_valid, wr_full,
                             output usb_data_t d, output usb_be_t be,
                             output logic wr_en, rd_en);
    d     = '0;                           // Idle row
    be    = 4'hF;
    wr_en = 1'b0;
    rd_en = 1'b0;
    case (m_mode)
        ROUTE_REGS: begin
            d     = m_wr_data;
            be    = m_be;
            wr_en = m_push;
            rd_en = m_pop;
        end
        ROUTE_ADC: begin
            d     = usb_data_t'(adc);     // Byte in the low lane
            wr_en = 1'b1;
            rd_en = 1'b1;
        end
        ROUTE_LOOP: begin
            d     = rd_data;
            be    = rd_be;
            wr_en = rd_valid;
            rd_en = !wr_full;
        end
        default: ;
    endcase
endtask

////////////////////////////////////////////////////////////////////////////
// Compare tasks
////////////////////////////////////////////////////////////////////////////

task automatic check_apb_data(input apb_data_t got, input apb_data_t exp, input string what);
    if (got !== exp)
        fail_now($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
endtask

task automatic check_usb_beat(input usb_data_t data, input usb_be_t be, input logic wr_en,
                              input logic rd_en, input usb_data_t exp_data,
                              input usb_be_t exp_be, input logic exp_wr_en,
                              input logic exp_rd_en, input logic data_used);
    if (wr_en !== exp_wr_en || rd_en !== exp_rd_en)
        fail_now($sformatf("FAILED at %0t: enables wr %b rd %b, expected wr %b rd %b",
                           $time, wr_en, rd_en, exp_wr_en, exp_rd_en));
    if (be !== exp_be)
        fail_now($sformatf("FAILED at %0t: usb_wr_be %h, expected %h", $time, be, exp_be));
    if (data_used && data !== exp_data)   // Word only defined once pushed
        fail_now($sformatf("FAILED at %0t: usb_wr_data %h, expected %h",
                           $time, data, exp_data));
endtask

task automatic check_led(input logic got, input logic exp, input string what);
    if (got !== exp)
        fail_now($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
endtask

`endif

// File: tests/r24_ctrl_tb.sv
`timescale 1ns/1ns
`default_nettype none

module r24_ctrl_tb
    import r24_ctrl_pkg::*;
();

    localparam logic [APB_ADDR_W-WINDOW_LSB-1:0] BLOCK_BASE = 20'h43C04;
    localparam int LED_DEPTH      = 16;
    localparam int STROBE_TIMEOUT = 8;    // Cycles allowed for a strobe
    localparam logic [1:0] FULL_RANDOM = 2'd0;
    localparam logic [1:0] FULL_LOW    = 2'd1;
    localparam logic [1:0] FULL_HIGH   = 2'd2;

    logic        clk;
    logic        reset;
    logic        psel, penable, pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    adc_sample_t adc_a_data;
    usb_data_t   usb_rd_data;
    usb_be_t     usb_rd_be;
    logic        usb_rd_valid, usb_rd_empty, usb_wr_full;
    usb_data_t   usb_wr_data;
    usb_be_t     usb_wr_be;
    logic        usb_wr_en, usb_rd_en, led0, led1;

    int          seed = 87;
    logic        reset_drive;             // Reset level for the next edge
    logic [1:0]  full_force;
    logic [11:0] offsets [9] = '{12'h000, 12'h004, 12'h008, 12'h00C, 12'h010,
                                 12'h014, 12'h018, 12'h01C, 12'hFFC};

    r24_ctrl_top #(.BLOCK_BASE(BLOCK_BASE), .LED_DEPTH(LED_DEPTH)) r24_ctrl_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    `include "r24_ctrl_model.svh"

    ////////////////////////////////////////////////////////////////////////
    // Cycle driver and per-cycle checks
    ////////////////////////////////////////////////////////////////////////

    task automatic check_outputs();
        usb_data_t exp_data;
        usb_be_t   exp_be;
        logic      exp_wr_en, exp_rd_en;
        if (reset)
            return;
        if (psel && penable && !pwrite)   // Read access cycle
            check_apb_data(prdata, predict_read(paddr, usb_wr_full, usb_rd_empty, usb_rd_data),
                           $sformatf("prdata at %h", paddr));
        predict_route(adc_a_data, usb_rd_data, usb_rd_be, usb_rd_valid, usb_wr_full,
                      exp_data, exp_be, exp_wr_en, exp_rd_en);
        check_usb_beat(usb_wr_data, usb_wr_be, usb_wr_en, usb_rd_en, exp_data, exp_be,
                       exp_wr_en, exp_rd_en, exp_wr_en || m_mode != ROUTE_REGS);
        check_led(led0, m_pin0, "led0");
        check_led(led1, m_pin1, "led1");
    endtask

    // One clock with fresh FIFO-side inputs, checked mid-cycle
    task automatic cycle(input logic sel, en, wr, input apb_addr_t addr, input apb_data_t data);
        logic [31:0] rnd;
        logic        full;
        @(posedge clk);
        model_step(reset, psel, penable, pwrite, paddr, pwdata, usb_wr_full);
        rnd  = $random(seed);
        full = rnd[6];
        if (full_force == FULL_LOW || m_mode == ROUTE_ADC)
            full = 1'b0;                  // ADC stream never sees full
        else if (full_force == FULL_HIGH)
            full = 1'b1;
        reset        <= reset_drive;
        psel         <= sel;
        penable      <= en;
        pwrite       <= wr;
        paddr        <= addr;
        pwdata       <= data;
        usb_wr_full  <= full;
        usb_rd_be    <= rnd[3:0];
        usb_rd_valid <= rnd[4];
        usb_rd_empty <= rnd[5];
        adc_a_data   <= rnd[15:8];
        usb_rd_data  <= $random(seed);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle_cycle();
        cycle(1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        cycle(1'b1, 1'b0, 1'b1, addr, data); // Setup
        cycle(1'b1, 1'b1, 1'b1, addr, data); // Access, lands on the next edge
    endtask

    task automatic apb_read(input apb_addr_t addr);
        cycle(1'b1, 1'b0, 1'b0, addr, '0);
        cycle(1'b1, 1'b1, 1'b0, addr, '0);   // prdata checked here
    endtask

    function automatic apb_addr_t reg_addr(input logic [WINDOW_LSB-1:0] offset);
        return {BLOCK_BASE, offset};
    endfunction

    task automatic wait_for_strobe(input logic rd);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen) begin
            if (waited == STROBE_TIMEOUT)
                fail_now($sformatf("Timed out after %0d cycles waiting for usb_%s_en",
                                   waited, rd ? "rd" : "wr"));
            idle_cycle();
            waited++;
            seen = rd ? usb_rd_en : usb_wr_en;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        logic [11:0] offset;
        apb_addr_t   addr;
        reset        = 1'b1;
        reset_drive  = 1'b1;
        full_force   = FULL_RANDOM;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        adc_a_data   = '0;
        usb_rd_data  = '0;
        usb_rd_be    = '0;
        usb_rd_valid = 1'b0;
        usb_rd_empty = 1'b1;
        usb_wr_full  = 1'b0;

        for (int i = 0; i < 5; i++) begin
            reset_drive = (i < 4);        // Fifth edge still samples reset high
            idle_cycle();
        end

        // Reset values
        check_usb_beat(usb_wr_data, usb_wr_be, usb_wr_en, usb_rd_en, '0, 4'hF,
                       1'b0, 1'b0, 1'b1);
        check_led(led0, 1'b0, "led0 after reset");
        check_led(led1, 1'b0, "led1 after reset");
        apb_read(reg_addr(REG_CTRL));
        apb_read(reg_addr(REG_USB_WR_BE));
        apb_read(reg_addr(REG_LED0));
        apb_read(reg_addr(REG_LED1));

        // Register-driven pushes, overflow and pop
        full_force = FULL_LOW;
        apb_write(reg_addr(REG_CTRL), ROUTE_REGS);
        apb_write(reg_addr(REG_USB_WR_BE), $random(seed));
        repeat (8) begin
            apb_write(reg_addr(REG_USB_WR_DATA), $random(seed));
            wait_for_strobe(1'b0);
        end
        full_force = FULL_HIGH;
        apb_write(reg_addr(REG_USB_WR_DATA), $random(seed));
        repeat (3) idle_cycle();
        apb_read(reg_addr(REG_STATUS));   // Overflow now set
        apb_write(reg_addr(REG_STATUS), $random(seed));
        apb_read(reg_addr(REG_STATUS));
        full_force = FULL_RANDOM;
        apb_write(reg_addr(REG_USB_RD_DATA), $random(seed));
        wait_for_strobe(1'b1);

        // Random traffic, one access in eight outside the window
        repeat (300) begin
            rnd    = $random(seed);
            offset = offsets[rnd[7:0] % 9];
            addr   = {BLOCK_BASE, offset};
            if (rnd[10:8] == 3'd0)
                addr = {BLOCK_BASE ^ (20'd1 << (rnd[20:16] % 20)), offset};
            if (rnd[11])
                apb_write(addr, $random(seed));
            else
                apb_read(addr);
        end

        // Routing table, checked every cycle
        apb_write(reg_addr(REG_CTRL), ROUTE_IDLE);
        repeat (100) idle_cycle();
        apb_write(reg_addr(REG_CTRL), ROUTE_ADC);
        repeat (100) idle_cycle();
        apb_write(reg_addr(REG_CTRL), ROUTE_LOOP);
        repeat (100) idle_cycle();

        // Dimmers
        apb_write(reg_addr(REG_LED0), $random(seed));
        apb_write(reg_addr(REG_LED1), $random(seed));
        repeat (400) idle_cycle();
        apb_write(reg_addr(REG_LED0), '0);
        repeat (2) idle_cycle();          // Last carry from the old level
        repeat (20) begin
            idle_cycle();
            check_led(led0, 1'b0, "led0 at zero brightness");
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
